//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_cspace
FILELIST  = sources.f
LOG       = sim.log
RUNOPTS   = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUNOPTS) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- control_map.sv
`timescale 1ns/1ps

module control_map (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	host_if.sink                         host,
	input  logic [cspace_pkg::joy_w-1:0] kbjoy,
	output logic                         ctl_ccw,
	output logic                         ctl_cw,
	output logic                         ctl_thrust,
	output logic                         ctl_fire,
	output logic                         ctl_start,
	output logic                         game_reset,
	output cspace_pkg::scan_mode_e       scan_mode
);
	import cspace_pkg::*;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ctl_ccw    <= 1'b0;
			ctl_cw     <= 1'b0;
			ctl_thrust <= 1'b0;
			ctl_fire   <= 1'b0;
			ctl_start  <= 1'b0;
			game_reset <= 1'b1;
			scan_mode  <= scan_none;
		end else begin
			ctl_ccw    <= kbjoy[kb_left] | host.joystick_0[joy_left] |
				host.joystick_1[joy_left];
			ctl_cw     <= kbjoy[kb_right] | host.joystick_0[joy_right] |
				host.joystick_1[joy_right];
			ctl_thrust <= kbjoy[kb_up] | host.joystick_0[joy_thrust] |
				host.joystick_1[joy_thrust];
			ctl_fire   <= kbjoy[kb_space] | host.joystick_0[joy_fire] |
				host.joystick_1[joy_fire];
			// Either number key starts a game
			ctl_start  <= kbjoy[kb_1] | kbjoy[kb_2] | host.status.f.start;
			game_reset <= host.buttons[1] | host.status.f.reset | host.status.f.reset_alt;
			scan_mode  <= host.status.f.scan_mode;
		end
	end

endmodule

//--- cspace_checker.sv
`timescale 1ns/1ps

module cspace_checker (
	input logic                clk_sys,
	input logic                rst_n,
	input logic                spi_ss,
	input cspace_pkg::status_u status,
	input logic                ctl_start,
	input logic                game_reset
);

	int reset_fails = 0;
	int status_fails = 0;
	int start_fails = 0;

	// game_reset is a register, so it shows the reset one cycle on
	reset_high: assert property (@(posedge clk_sys) !rst_n |=> game_reset)
		else begin
			reset_fails++;
			$error("game_reset not high while rst_n is low");
		end

	status_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(spi_ss && $past(spi_ss)) |-> $stable(status))
		else begin
			status_fails++;
			$error("status word changed while SPI_SS2 was high");
		end

	start_follow: assert property (@(posedge clk_sys) disable iff (!rst_n)
		status.f.start |=> ctl_start)
		else begin
			start_fails++;
			$error("ctl_start did not follow the status start bit");
		end

endmodule

// Placed at the top so that both the SPI link and the control mapper are visible
bind cspace_io_top cspace_checker chk (
	.clk_sys    (clk_sys),
	.rst_n      (rst_n),
	.spi_ss     (SPI_SS2),
	.status     (host.status),
	.ctl_start  (ctl_start),
	.game_reset (game_reset)
);

//--- cspace_io_top.sv
`timescale 1ns/1ps

module cspace_io_top #(
	parameter int AUDIO_W = 16
) (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               SPI_SCK,
	input  logic               SPI_DI,
	input  logic               SPI_SS2,
	input  logic               ps2_kbd_clk,
	input  logic               ps2_kbd_data,
	input  logic               game_video,
	input  logic               game_blank,
	input  logic               game_hsync,
	input  logic               game_vsync,
	input  logic [AUDIO_W-1:0] game_audio,
	output logic [5:0]         VGA_R,
	output logic [5:0]         VGA_G,
	output logic [5:0]         VGA_B,
	output logic               VGA_HS,
	output logic               VGA_VS,
	output logic               AUDIO_L,
	output logic               AUDIO_R,
	output logic               ctl_ccw,
	output logic               ctl_cw,
	output logic               ctl_thrust,
	output logic               ctl_fire,
	output logic               ctl_start,
	output logic               game_reset
);
	import cspace_pkg::*;

	logic [joy_w-1:0] kbjoy;
	scan_mode_e       scan_mode;

	host_if host ();

	spi_host_link spi_link (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.spi_sck (SPI_SCK),
		.spi_di  (SPI_DI),
		.spi_ss  (SPI_SS2),
		.host    (host.link)
	);

	ps2_joystick keyboard (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.ps2_clk  (ps2_kbd_clk),
		.ps2_data (ps2_kbd_data),
		.joystick (kbjoy)
	);

	control_map ctl_map (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.host       (host.sink),
		.kbjoy      (kbjoy),
		.ctl_ccw    (ctl_ccw),
		.ctl_cw     (ctl_cw),
		.ctl_thrust (ctl_thrust),
		.ctl_fire   (ctl_fire),
		.ctl_start  (ctl_start),
		.game_reset (game_reset),
		.scan_mode  (scan_mode)
	);

	video_out #(.COLOR_W(6)) vid_out (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.video     (game_video),
		.blank     (game_blank),
		.hsync     (game_hsync),
		.vsync     (game_vsync),
		.scan_mode (scan_mode),
		.r         (VGA_R),
		.g         (VGA_G),
		.b         (VGA_B),
		.hs        (VGA_HS),
		.vs        (VGA_VS)
	);

	// Mono game audio on both channels
	sigma_delta_dac #(.DAC_WIDTH(AUDIO_W)) dac_l (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.din     (game_audio),
		.dout    (AUDIO_L)
	);

	sigma_delta_dac #(.DAC_WIDTH(AUDIO_W)) dac_r (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.din     (game_audio),
		.dout    (AUDIO_R)
	);

endmodule

//--- cspace_pkg.sv
package cspace_pkg;

	localparam int joy_w = 8;
	localparam int status_w = 32;

	// First byte of an SPI transfer
	localparam logic [7:0] cmd_buttons = 8'h01;
	localparam logic [7:0] cmd_joy0    = 8'h02;
	localparam logic [7:0] cmd_joy1    = 8'h03;
	localparam logic [7:0] cmd_status  = 8'h1E;

	// PS/2 set 2 scan codes of the game keys
	localparam logic [7:0] sc_left  = 8'h6B;
	localparam logic [7:0] sc_right = 8'h74;
	localparam logic [7:0] sc_up    = 8'h75;
	localparam logic [7:0] sc_space = 8'h29;
	localparam logic [7:0] sc_1     = 8'h16;
	localparam logic [7:0] sc_2     = 8'h1E;
	localparam logic [7:0] sc_ext   = 8'hE0;
	localparam logic [7:0] sc_break = 8'hF0;

	// Keyboard joystick byte
	localparam int kb_space = 0;
	localparam int kb_2     = 1;
	localparam int kb_1     = 3;
	localparam int kb_up    = 4;
	localparam int kb_left  = 6;
	localparam int kb_right = 7;

	// Host joystick words
	localparam int joy_right  = 0;
	localparam int joy_left   = 1;
	localparam int joy_thrust = 3;
	localparam int joy_fire   = 4;

	typedef enum logic [1:0] {
		scan_none  = 2'd0,
		scan_hq2x  = 2'd1,
		scan_crt25 = 2'd2,
		scan_crt50 = 2'd3
	} scan_mode_e;

	// Filled bytewise by the SPI link, read as fields by the control mapper
	typedef union packed {
		logic [status_w/8-1:0][7:0] bytes;
		struct packed {
			logic [status_w-8:0] spare_hi;
			logic                reset_alt;
			logic                spare_5;
			scan_mode_e          scan_mode;
			logic                start;
			logic                spare_1;
			logic                reset;
		} f;
	} status_u;

endpackage

//--- host_if.sv
`timescale 1ns/1ps

interface host_if;
	import cspace_pkg::*;

	logic [1:0]       buttons;
	logic [joy_w-1:0] joystick_0;
	logic [joy_w-1:0] joystick_1;
	status_u          status;

	modport link (
		output buttons,
		output joystick_0,
		output joystick_1,
		output status
	);

	modport sink (
		input buttons,
		input joystick_0,
		input joystick_1,
		input status
	);

endinterface

//--- ps2_joystick.sv
`timescale 1ns/1ps

module ps2_joystick (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  logic                         ps2_clk,
	input  logic                         ps2_data,
	output logic [cspace_pkg::joy_w-1:0] joystick
);
	import cspace_pkg::*;

	logic [1:0]       clk_sync;
	logic [1:0]       data_sync;
	logic             clk_prev;
	logic             clk_fall;
	logic [10:0]      frame;
	logic [3:0]       bit_cnt;
	logic             frame_done;
	logic             frame_ok;
	logic [7:0]       code;
	logic             brk;
	logic [joy_w-1:0] key_mask;

	assign clk_fall = clk_prev & ~clk_sync[1];
	assign code     = frame[8:1];
	// Start low, stop high, odd parity over data plus parity bit
	assign frame_ok = frame_done & ~frame[0] & frame[10] & (^frame[9:1]);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev  <= clk_sync[1];
		end
	end

	// LSB arrives first, so shift in from the top
	always_ff @(posedge clk_sys) begin
		if (clk_fall) begin
			frame <= {data_sync[1], frame[10:1]};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			bit_cnt    <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (clk_fall && (bit_cnt != 4'd0 || !data_sync[1])) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt    <= '0;
					frame_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

	always_comb begin
		key_mask = '0;
		case (code)
			sc_left:  key_mask[kb_left]  = 1'b1;
			sc_right: key_mask[kb_right] = 1'b1;
			sc_up:    key_mask[kb_up]    = 1'b1;
			sc_space: key_mask[kb_space] = 1'b1;
			sc_1:     key_mask[kb_1]     = 1'b1;
			sc_2:     key_mask[kb_2]     = 1'b1;
			default:  key_mask = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			joystick <= '0;
			brk      <= 1'b0;
		end else if (frame_ok) begin
			if (code == sc_break) begin
				brk <= 1'b1;
			end else if (code != sc_ext) begin
				brk      <= 1'b0;
				joystick <= brk ? (joystick & ~key_mask) : (joystick | key_mask);
			end
		end
	end

endmodule

//--- sigma_delta_dac.sv
`timescale 1ns/1ps

module sigma_delta_dac #(
	parameter int DAC_WIDTH = 16
) (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic [DAC_WIDTH-1:0] din,
	output logic                 dout
);

	// Top bit holds the carry of the last addition
	logic [DAC_WIDTH:0] acc;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[DAC_WIDTH-1:0]} + {1'b0, din};
		end
	end

	assign dout = acc[DAC_WIDTH];

endmodule

//--- sources.f
cspace_pkg.sv
host_if.sv
spi_host_link.sv
ps2_joystick.sv
control_map.sv
sigma_delta_dac.sv
video_out.sv
cspace_io_top.sv
cspace_checker.sv
tb_monitor.sv
tb_cspace.sv

//--- spi_host_link.sv
`timescale 1ns/1ps

module spi_host_link (
	input logic  clk_sys,
	input logic  rst_n,
	input logic  spi_sck,
	input logic  spi_di,
	input logic  spi_ss,
	host_if.link host
);
	import cspace_pkg::*;

	logic [1:0] sck_sync;
	logic [1:0] di_sync;
	logic [1:0] ss_sync;
	logic       sck_prev;
	logic       sck_rise;
	logic [7:0] shreg;
	logic [2:0] bit_cnt;
	logic       byte_done;
	logic [2:0] byte_cnt;
	logic [7:0] cmd;
	logic [1:0] status_idx;

	assign sck_rise = sck_sync[1] & ~sck_prev;
	// Data bytes 1..4 land in status bytes 0..3
	assign status_idx = byte_cnt[1:0] - 2'd1;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			sck_sync <= 2'b00;
			di_sync  <= 2'b00;
			ss_sync  <= 2'b11;
			sck_prev <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[0], spi_sck};
			di_sync  <= {di_sync[0], spi_di};
			ss_sync  <= {ss_sync[0], spi_ss};
			sck_prev <= sck_sync[1];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sck_rise) begin
			shreg <= {shreg[6:0], di_sync[1]};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n || ss_sync[1]) begin
			bit_cnt   <= '0;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (sck_rise) begin
				bit_cnt   <= bit_cnt + 3'd1;
				byte_done <= (bit_cnt == 3'd7);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			host.buttons    <= '0;
			host.joystick_0 <= '0;
			host.joystick_1 <= '0;
			host.status     <= '0;
			cmd             <= '0;
			byte_cnt        <= '0;
		end else begin
			if (byte_done) begin
				if (byte_cnt == 3'd0) begin
					cmd <= shreg;
				end else begin
					case (cmd)
						cmd_buttons: begin
							if (byte_cnt == 3'd1)
								host.buttons <= shreg[1:0];
						end
						cmd_joy0: begin
							if (byte_cnt == 3'd1)
								host.joystick_0 <= shreg;
						end
						cmd_joy1: begin
							if (byte_cnt == 3'd1)
								host.joystick_1 <= shreg;
						end
						cmd_status: begin
							if (byte_cnt <= 3'd4)
								host.status.bytes[status_idx] <= shreg;
						end
						default: begin
						end
					endcase
				end
				// Saturate so trailing bytes are dropped
				if (byte_cnt != 3'd7)
					byte_cnt <= byte_cnt + 3'd1;
			end
			if (ss_sync[1]) begin
				byte_cnt <= '0;
			end
		end
	end

endmodule

//--- tb_cspace.sv
`timescale 1ns/1ps

module tb_cspace;
	import cspace_pkg::*;

	localparam int n_joy   = 8;
	localparam int n_stat  = 4;
	localparam int n_keys  = 16;
	localparam int burst   = 64;
	localparam int vid_len = 256;
	// SPI transfer is 12 cycles of framing plus 48 per byte
	localparam int spi_short = 12 + 2 * 48;
	localparam int spi_long  = 12 + 5 * 48;
	localparam int ps2_len   = 11 * 20 + 10;
	localparam int tb_len = 12 + n_joy * (3 * spi_short + 1)
		+ n_stat * (spi_long + burst + 2)
		+ 2 * spi_short + spi_long + (2 * n_keys + 1) * (ps2_len + 6)
		+ 4 * (spi_long + vid_len + 2)
		+ 3 * (16 + 1024 + 1) + 10;
	localparam int limit = 2 * tb_len;

	logic        clk_sys = 1'b0;
	logic        rst_n;
	logic        spi_sck, spi_di, spi_ss2;
	logic        ps2_clk, ps2_data;
	logic        game_video, game_blank, game_hsync, game_vsync;
	logic [15:0] game_audio;
	logic [5:0]  vga_r, vga_g, vga_b;
	logic        vga_hs, vga_vs, audio_l, audio_r;
	logic        ctl_ccw, ctl_cw, ctl_thrust, ctl_fire, ctl_start, game_reset;

	logic [2:0]  test_id;
	logic        chk_en, cnt_en, test_done, all_done;
	logic [1:0]  chk_kind;
	logic [19:0] exp_val;
	int          err_count;
	int          asrt_fails;
	int          cycles = 0;
	int          seed;

	// Model state
	logic [1:0]  exp_btn;
	logic [7:0]  exp_j0, exp_j1, exp_kb;
	logic [31:0] exp_status;
	logic        odd, prev_v, prev_b, prev_hs, prev_vs, prev2_hs;

	logic [7:0] key_codes [6] = '{8'h6B, 8'h74, 8'h75, 8'h29, 8'h16, 8'h1E};
	int         key_bits [6] = '{6, 7, 4, 0, 3, 1};

	always #2 clk_sys = ~clk_sys;

	cspace_io_top #(.AUDIO_W(16)) dut0 (
		.clk_sys (clk_sys), .rst_n (rst_n),
		.SPI_SCK (spi_sck), .SPI_DI (spi_di), .SPI_SS2 (spi_ss2),
		.ps2_kbd_clk (ps2_clk), .ps2_kbd_data (ps2_data),
		.game_video (game_video), .game_blank (game_blank),
		.game_hsync (game_hsync), .game_vsync (game_vsync), .game_audio (game_audio),
		.VGA_R (vga_r), .VGA_G (vga_g), .VGA_B (vga_b), .VGA_HS (vga_hs), .VGA_VS (vga_vs),
		.AUDIO_L (audio_l), .AUDIO_R (audio_r),
		.ctl_ccw (ctl_ccw), .ctl_cw (ctl_cw), .ctl_thrust (ctl_thrust),
		.ctl_fire (ctl_fire), .ctl_start (ctl_start), .game_reset (game_reset)
	);

	tb_monitor mon (
		.clk_sys (clk_sys), .test_id (test_id), .chk_en (chk_en), .chk_kind (chk_kind),
		.exp_val (exp_val), .cnt_en (cnt_en), .test_done (test_done), .all_done (all_done),
		.ctl ({game_reset, ctl_start, ctl_fire, ctl_thrust, ctl_cw, ctl_ccw}),
		.vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b), .vga_hs (vga_hs), .vga_vs (vga_vs),
		.audio_l (audio_l), .audio_r (audio_r), .err_count (err_count)
	);

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	// Each control ORs the keyboard with both joysticks
	function automatic logic [5:0] ctl_word();
		logic ccw, cw, thr, fire, start, grst;
		ccw   = exp_kb[6] | exp_j0[1] | exp_j1[1];
		cw    = exp_kb[7] | exp_j0[0] | exp_j1[0];
		thr   = exp_kb[4] | exp_j0[3] | exp_j1[3];
		fire  = exp_kb[0] | exp_j0[4] | exp_j1[4];
		start = exp_kb[3] | exp_kb[1] | exp_status[2];
		grst  = exp_btn[1] | exp_status[0] | exp_status[6];
		return {grst, start, fire, thr, cw, ccw};
	endfunction

	function automatic logic [5:0] intensity(input logic v, input logic bl, input logic odd_l,
		input logic [1:0] mode);
		if (bl || !v)
			return 6'd0;
		if (odd_l && mode == 2'd2)
			return 6'd47;
		if (odd_l && mode == 2'd3)
			return 6'd31;
		return 6'd63;
	endfunction

	task automatic clocks(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	// Mode 0, MSB first, one byte of command then data bytes LSB first
	task automatic spi_send(input logic [7:0] cmd, input int nbytes, input logic [31:0] data);
		int         k;
		int         i;
		logic [7:0] b;
		spi_ss2 <= 1'b0;
		clocks(3);
		for (k = 0; k <= nbytes; k++) begin
			if (k == 0)
				b = cmd;
			else
				b = data[8*(k-1) +: 8];
			for (i = 7; i >= 0; i--) begin
				spi_sck <= 1'b0;
				spi_di  <= b[i];
				clocks(3);
				spi_sck <= 1'b1;
				clocks(3);
			end
		end
		spi_sck <= 1'b0;
		clocks(3);
		spi_ss2 <= 1'b1;
		clocks(6);
	endtask

	task automatic ps2_send(input logic [7:0] code, input logic bad_parity);
		logic [10:0] fr;
		int          i;
		fr = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
		for (i = 0; i < 11; i++) begin
			ps2_data <= fr[i];
			clocks(10);
			ps2_clk <= 1'b0;
			clocks(10);
			ps2_clk <= 1'b1;
		end
		ps2_data <= 1'b1;
		clocks(10);
	endtask

	task automatic check_ctl();
		chk_kind <= 2'd0;
		exp_val  <= {14'd0, ctl_word()};
		chk_en   <= 1'b1;
		clocks(1);
		chk_en <= 1'b0;
	endtask

	task automatic end_test();
		test_done <= 1'b1;
		clocks(1);
		test_done <= 1'b0;
	endtask

	// Output after each edge reflects the inputs driven one edge earlier
	task automatic run_video(input int n);
		int          i;
		logic [31:0] r;
		logic [5:0]  lvl;
		odd = odd ^ (prev_hs & ~prev2_hs);
		prev2_hs = prev_hs;
		chk_kind <= 2'd1;
		for (i = 0; i < n; i++) begin
			lvl = intensity(prev_v, prev_b, odd, exp_status[4:3]);
			exp_val <= {lvl, lvl, lvl, prev_hs, prev_vs};
			chk_en  <= 1'b1;
			odd = odd ^ (prev_hs & ~prev2_hs);
			prev2_hs = prev_hs;
			r = rand32();
			game_video <= r[0];
			game_blank <= r[1] & r[2];
			game_hsync <= r[3];
			game_vsync <= r[4];
			prev_v  = r[0];
			prev_b  = r[1] & r[2];
			prev_hs = r[3];
			prev_vs = r[4];
			clocks(1);
		end
		chk_en <= 1'b0;
	endtask

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles == limit) begin
			$display("Timeout after %0d cycles, the tests did not finish", limit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		int          n;
		int          idx;
		logic [31:0] r;
		logic [15:0] aud;
		seed = 35;
		rst_n = 1'b0;
		spi_sck = 1'b0;
		spi_di = 1'b0;
		spi_ss2 = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		game_video = 1'b0;
		game_blank = 1'b0;
		game_hsync = 1'b0;
		game_vsync = 1'b0;
		game_audio = 16'd0;
		test_id = 3'd1;
		chk_en = 1'b0;
		chk_kind = 2'd0;
		exp_val = '0;
		cnt_en = 1'b0;
		test_done = 1'b0;
		all_done = 1'b0;
		exp_btn = '0;
		exp_j0 = '0;
		exp_j1 = '0;
		exp_kb = '0;
		exp_status = '0;
		odd = 1'b0;
		prev_v = 1'b0;
		prev_b = 1'b0;
		prev_hs = 1'b0;
		prev_vs = 1'b0;
		prev2_hs = 1'b0;

		// Only game_reset is high while in reset
		clocks(6);
		exp_val <= 20'h00020;
		chk_en  <= 1'b1;
		clocks(1);
		chk_en <= 1'b0;
		clocks(1);
		rst_n <= 1'b1;
		clocks(2);

		for (n = 0; n < n_joy; n++) begin
			r = rand32();
			exp_j0 = r[7:0];
			exp_j1 = r[15:8];
			exp_btn = r[17:16];
			spi_send(cmd_joy0, 1, {24'd0, r[7:0]});
			spi_send(cmd_joy1, 1, {24'd0, r[15:8]});
			spi_send(cmd_buttons, 1, {24'd0, r[23:16]});
			check_ctl();
		end
		end_test();

		test_id <= 3'd2;
		for (n = 0; n < n_stat; n++) begin
			exp_status = rand32();
			spi_send(cmd_status, 4, exp_status);
			check_ctl();
			run_video(burst);
		end
		end_test();

		// Clear host words so the keyboard alone drives the controls
		test_id <= 3'd3;
		exp_j0 = '0;
		exp_j1 = '0;
		exp_status = '0;
		spi_send(cmd_joy0, 1, 32'd0);
		spi_send(cmd_joy1, 1, 32'd0);
		spi_send(cmd_status, 4, 32'd0);
		ps2_send(key_codes[0], 1'b1);
		check_ctl();
		for (n = 0; n < n_keys; n++) begin
			r = rand32();
			idx = int'(r[7:0] % 8'd6);
			if (r[8]) begin
				ps2_send(8'hF0, 1'b0);
				ps2_send(key_codes[idx], 1'b0);
				exp_kb[key_bits[idx]] = 1'b0;
			end else begin
				ps2_send(key_codes[idx], 1'b0);
				exp_kb[key_bits[idx]] = 1'b1;
			end
			check_ctl();
		end
		end_test();

		test_id <= 3'd4;
		for (n = 0; n < 4; n++) begin
			r = rand32();
			r[4:3] = n[1:0];
			exp_status = r;
			spi_send(cmd_status, 4, r);
			run_video(vid_len);
		end
		end_test();

		test_id <= 3'd5;
		for (n = 0; n < 3; n++) begin
			r = rand32();
			aud = r[15:0];
			game_audio <= aud;
			clocks(16);
			cnt_en <= 1'b1;
			clocks(1024);
			cnt_en   <= 1'b0;
			chk_kind <= 2'd2;
			exp_val  <= {10'd0, aud[15:6]};
			chk_en   <= 1'b1;
			clocks(1);
			chk_en <= 1'b0;
		end
		end_test();

		all_done <= 1'b1;
		clocks(1);
		all_done <= 1'b0;
		clocks(1);
		asrt_fails = dut0.chk.reset_fails + dut0.chk.status_fails + dut0.chk.start_fails;
		if (asrt_fails != 0)
			$display("%0d assertion failures were reported by the checker", asrt_fails);
		if (err_count == 0 && asrt_fails == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- tb_monitor.sv
`timescale 1ns/1ps

module tb_monitor (
	input  logic        clk_sys,
	input  logic [2:0]  test_id,
	input  logic        chk_en,
	input  logic [1:0]  chk_kind,
	input  logic [19:0] exp_val,
	input  logic        cnt_en,
	input  logic        test_done,
	input  logic        all_done,
	input  logic [5:0]  ctl,
	input  logic [5:0]  vga_r,
	input  logic [5:0]  vga_g,
	input  logic [5:0]  vga_b,
	input  logic        vga_hs,
	input  logic        vga_vs,
	input  logic        audio_l,
	input  logic        audio_r,
	output int          err_count
);

	int          checks = 0;
	int          test_checks = 0;
	int          test_errs = 0;
	int          ones = 0;
	int          lr_diff = 0;
	int          exp_n;
	logic [19:0] act;

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd1: return "spi_joystick";
			3'd2: return "spi_status";
			3'd3: return "ps2_keys";
			3'd4: return "video_modes";
			3'd5: return "audio_dac";
			default: return "unknown";
		endcase
	endfunction

	initial err_count = 0;

	// Outputs are sampled mid-cycle, away from the driving edge
	always @(negedge clk_sys) begin
		if (cnt_en) begin
			if (audio_l)
				ones = ones + 1;
			if (audio_l != audio_r)
				lr_diff = lr_diff + 1;
		end
		if (chk_en) begin
			checks = checks + 1;
			test_checks = test_checks + 1;
			if (chk_kind == 2'd2) begin
				exp_n = {12'd0, exp_val};
				// Density may miss the ideal count by one either way
				if (ones < exp_n - 1 || ones > exp_n + 1) begin
					$display("ERROR %s: expected %0d actual %0d", test_name(test_id), exp_n, ones);
					test_errs = test_errs + 1;
					err_count = err_count + 1;
				end
				if (lr_diff != 0) begin
					$display("%s: AUDIO_L and AUDIO_R differed on %0d cycles",
						test_name(test_id), lr_diff);
					test_errs = test_errs + 1;
					err_count = err_count + 1;
				end
				ones = 0;
				lr_diff = 0;
			end else begin
				if (chk_kind == 2'd0)
					act = {14'd0, ctl};
				else
					act = {vga_r, vga_g, vga_b, vga_hs, vga_vs};
				if (act != exp_val) begin
					$display("ERROR %s: expected 'h%0h actual 'h%0h", test_name(test_id),
						exp_val, act);
					test_errs = test_errs + 1;
					err_count = err_count + 1;
				end
			end
		end
		if (test_done) begin
			if (test_errs == 0)
				$display("test %s passed, %0d checks", test_name(test_id), test_checks);
			else
				$display("test %s failed, %0d of %0d checks wrong", test_name(test_id),
					test_errs, test_checks);
			test_checks = 0;
			test_errs = 0;
		end
		if (all_done)
			$display("Totals: %0d checks, %0d errors", checks, err_count);
	end

endmodule

//--- video_out.sv
`timescale 1ns/1ps

module video_out #(
	parameter int COLOR_W = 6
) (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   video,
	input  logic                   blank,
	input  logic                   hsync,
	input  logic                   vsync,
	input  cspace_pkg::scan_mode_e scan_mode,
	output logic [COLOR_W-1:0]     r,
	output logic [COLOR_W-1:0]     g,
	output logic [COLOR_W-1:0]     b,
	output logic                   hs,
	output logic                   vs
);
	import cspace_pkg::*;

	// 47 and 31 of 63 at six bits
	localparam logic [COLOR_W-1:0] full  = '1;
	localparam logic [COLOR_W-1:0] dim25 = full - (COLOR_W)'(1 << (COLOR_W - 2));
	localparam logic [COLOR_W-1:0] dim50 = full >> 1;

	logic               hsync_d;
	logic               odd_line;
	logic [COLOR_W-1:0] level;

	always_comb begin
		if (blank || !video)
			level = '0;
		else if (odd_line && scan_mode == scan_crt25)
			level = dim25;
		else if (odd_line && scan_mode == scan_crt50)
			level = dim50;
		else
			level = full;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hsync_d  <= 1'b0;
			odd_line <= 1'b0;
			r        <= '0;
			g        <= '0;
			b        <= '0;
			hs       <= 1'b0;
			vs       <= 1'b0;
		end else begin
			hsync_d <= hsync;
			if (hsync && !hsync_d)
				odd_line <= ~odd_line;
			r  <= level;
			g  <= level;
			b  <= level;
			hs <= hsync;
			vs <= vsync;
		end
	end

endmodule
